// File: source/gvp_pkg.sv
package gvp_pkg;

    ////////////////////////////////////////////////////////////////////
    // program memory sizes
    ////////////////////////////////////////////////////////////////////

    localparam int vec_count  = 16;  // vectors in program memory
    localparam int vec_addr_w = 4;   // log2 of vec_count
    localparam int next_w     = 5;   // signed jump, one bit over address

    ////////////////////////////////////////////////////////////////////
    // data path widths
    ////////////////////////////////////////////////////////////////////

    localparam int data_w = 32;  // fields, increments, positions
    localparam int time_w = 48;  // run-time counter

    // options word sent with the end mark
    localparam logic [data_w-1:0] end_options = '1;

    // sequencer states
    typedef enum logic [1:0]
    {
        seq_hold = 2'd0,  // held at vector 0 by run_hold
        seq_load = 2'd1,  // fetch vector at pc
        seq_step = 2'd2,  // stepping through points
        seq_done = 2'd3   // end mark seen, wait for run_hold
    } seq_state_t;

    // store codes for the downstream recorder
    typedef enum logic [1:0]
    {
        store_none   = 2'd0,
        store_point  = 2'd1,  // data point
        store_header = 2'd2,  // section header
        store_end    = 2'd3   // end of program
    } store_code_t;

endpackage

// File: source/gvp_vector_store.sv
module gvp_vector_store
    import gvp_pkg::*;
(
    input  logic                     a_clk,
    input  logic                     reset_flg,
    // programming port
    input  logic                     setvec,       // one cycle write strobe
    input  logic [vec_addr_w-1:0]    vec_addr,
    input  logic [data_w-1:0]        vec_n,
    input  logic [data_w-1:0]        vec_iin,
    input  logic [data_w-1:0]        vec_options,
    input  logic [data_w-1:0]        vec_nrep,
    input  logic signed [next_w-1:0] vec_next,
    input  logic [data_w-1:0]        vec_deci,
    input  logic signed [data_w-1:0] vec_dx,
    input  logic signed [data_w-1:0] vec_dy,
    input  logic signed [data_w-1:0] vec_dz,
    input  logic signed [data_w-1:0] vec_du,
    // sequencer side
    input  logic [vec_addr_w-1:0]    pc,
    input  logic                     loop_dec,     // loop taken, count down
    input  logic                     loop_reload,  // loop exhausted, rearm
    output logic [data_w-1:0]        cur_n,
    output logic [data_w-1:0]        cur_iin,
    output logic [data_w-1:0]        cur_options,
    output logic signed [next_w-1:0] cur_next,
    output logic [data_w-1:0]        cur_deci,
    output logic signed [data_w-1:0] cur_dx,
    output logic signed [data_w-1:0] cur_dy,
    output logic signed [data_w-1:0] cur_dz,
    output logic signed [data_w-1:0] cur_du,
    output logic [data_w-1:0]        loop_count
);

    // vector fields, one entry per program slot
    logic [data_w-1:0]        mem_n       [vec_count];
    logic [data_w-1:0]        mem_iin     [vec_count];
    logic [data_w-1:0]        mem_options [vec_count];
    logic [data_w-1:0]        mem_nrep    [vec_count];
    logic signed [next_w-1:0] mem_next    [vec_count];
    logic [data_w-1:0]        mem_deci    [vec_count];
    logic signed [data_w-1:0] mem_dx      [vec_count];
    logic signed [data_w-1:0] mem_dy      [vec_count];
    logic signed [data_w-1:0] mem_dz      [vec_count];
    logic signed [data_w-1:0] mem_du      [vec_count];

    logic [data_w-1:0]        loop_cnt    [vec_count];  // live repeat counters

    // field write, only done while held
    always_ff @(posedge a_clk)
    begin
        if (setvec)
        begin
            mem_n[vec_addr]       <= vec_n;
            mem_iin[vec_addr]     <= vec_iin;
            mem_options[vec_addr] <= vec_options;
            mem_nrep[vec_addr]    <= vec_nrep;
            mem_next[vec_addr]    <= vec_next;
            mem_deci[vec_addr]    <= vec_deci;
            mem_dx[vec_addr]      <= vec_dx;
            mem_dy[vec_addr]      <= vec_dy;
            mem_dz[vec_addr]      <= vec_dz;
            mem_du[vec_addr]      <= vec_du;
        end
    end

    // loop counters, armed by the write and updated at section ends
    always_ff @(posedge a_clk)
    begin
        if (reset_flg)
        begin
            for (int k = 0; k < vec_count; k++)
            begin
                loop_cnt[k] <= '0;
            end
        end
        else if (setvec)
            loop_cnt[vec_addr] <= vec_nrep;
        else if (loop_dec)
            loop_cnt[pc] <= loop_cnt[pc] - 1'b1;
        else if (loop_reload)
            loop_cnt[pc] <= mem_nrep[pc];   // ready for the next pass
    end

    // async read at pc
    assign cur_n       = mem_n[pc];
    assign cur_iin     = mem_iin[pc];
    assign cur_options = mem_options[pc];
    assign cur_next    = mem_next[pc];
    assign cur_deci    = mem_deci[pc];
    assign cur_dx      = mem_dx[pc];
    assign cur_dy      = mem_dy[pc];
    assign cur_dz      = mem_dz[pc];
    assign cur_du      = mem_du[pc];
    assign loop_count  = loop_cnt[pc];

endmodule

// File: source/gvp_sequencer.sv
module gvp_sequencer
    import gvp_pkg::*;
(
    input  logic                     a_clk,
    input  logic                     reset_flg,
    input  logic                     run_hold,    // level, high holds at vector 0
    input  logic                     pause,
    input  logic                     stall,       // downstream not ready
    // current vector from the store
    input  logic [data_w-1:0]        cur_n,
    input  logic [data_w-1:0]        cur_iin,
    input  logic signed [next_w-1:0] cur_next,
    input  logic [data_w-1:0]        cur_deci,
    input  logic [data_w-1:0]        loop_count,
    // store control
    output logic [vec_addr_w-1:0]    pc,
    output logic                     loop_dec,
    output logic                     loop_reload,
    // accumulator control
    output logic                     step,
    output logic                     clear_u,
    // output stage
    output store_code_t              store_code,  // valid in the tick only
    output seq_state_t               state,
    output logic [data_w-1:0]        index,
    output logic                     gvp_hold
);

    logic              run_hold_r;   // registered run_hold
    logic              hold_r;       // registered pause or stall
    logic [data_w-1:0] decimation;   // active decimation
    logic [data_w-1:0] deci_cnt;     // countdown to next tick
    logic [data_w-1:0] pt_cnt;       // points left in section
    logic [data_w-1:0] st_cnt;       // intermediate steps left
    logic              tick;
    logic              step_go;
    logic              sec_end;
    logic [next_w-1:0] pc_jump;

    ////////////////////////////////////////////////////////////////////
    // tick and step decode
    ////////////////////////////////////////////////////////////////////

    assign tick    = (deci_cnt == '0);
    assign step_go = tick && !run_hold_r && !hold_r && (state == seq_step);
    assign sec_end = step_go && (st_cnt == '0) && (pt_cnt == '0);

    assign step        = step_go;                       // every unpaused tick adds
    assign loop_dec    = sec_end && (loop_count != '0);
    assign loop_reload = sec_end && (loop_count == '0);
    assign clear_u     = (state == seq_hold);

    // relative jump, wraps inside the program memory
    assign pc_jump = {1'b0, pc} + cur_next;

    assign index    = pt_cnt;
    assign gvp_hold = hold_r;

    // store code for this tick
    always_comb
    begin
        store_code = store_none;
        if (tick && !run_hold_r)
        begin
            if (state == seq_load)
            begin
                if (cur_n == '0)
                    store_code = store_end;      // n of 0 ends the program
                else
                    store_code = store_header;
            end
            else if (step_go && (st_cnt == '0) && (pt_cnt != '0))
                store_code = store_point;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // control FSM
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (reset_flg)
        begin
            run_hold_r <= 1'b1;  // held until run_hold is seen low
            hold_r     <= 1'b0;
            state      <= seq_hold;
            pc         <= '0;
            decimation <= '0;
            deci_cnt   <= '0;
            pt_cnt     <= '0;
            st_cnt     <= '0;
        end
        else
        begin
            run_hold_r <= run_hold;
            hold_r     <= pause | stall;
            if (run_hold_r)
            begin
                state      <= seq_hold;
                pc         <= '0;
                decimation <= '0;  // tick on every cycle
                deci_cnt   <= '0;
                pt_cnt     <= '0;
                st_cnt     <= '0;
            end
            else if (!tick)
                deci_cnt <= deci_cnt - 1'b1;
            else
            begin
                deci_cnt <= decimation;
                case (state)
                    seq_hold:
                    begin
                        state <= seq_load;  // released, fetch vector 0
                    end
                    seq_load:
                    begin
                        pt_cnt <= cur_n;
                        st_cnt <= cur_iin;
                        if (cur_n == '0)
                            state <= seq_done;
                        else
                        begin
                            decimation <= cur_deci;
                            deci_cnt   <= cur_deci;  // first step d+1 cycles on
                            state      <= seq_step;
                        end
                    end
                    seq_step:
                    begin
                        if (step_go)
                        begin
                            if (st_cnt != '0)
                                st_cnt <= st_cnt - 1'b1;   // intermediate step
                            else if (pt_cnt != '0)
                            begin
                                st_cnt <= cur_iin;         // data point
                                pt_cnt <= pt_cnt - 1'b1;
                            end
                            else
                            begin
                                if (loop_dec)
                                    pc <= pc_jump[vec_addr_w-1:0];  // back to loop head
                                else
                                    pc <= pc + 1'b1;
                                state <= seq_load;
                            end
                        end
                    end
                    default:
                    begin
                        state <= seq_done;  // wait for run_hold
                    end
                endcase
            end
        end
    end

endmodule

// File: source/gvp_accumulator.sv
module gvp_accumulator
    import gvp_pkg::*;
(
    input  logic                     a_clk,
    input  logic                     reset_flg,
    input  logic                     step,     // add increments this cycle
    input  logic                     clear_u,  // level, zero u while held
    input  logic signed [data_w-1:0] cur_dx,
    input  logic signed [data_w-1:0] cur_dy,
    input  logic signed [data_w-1:0] cur_dz,
    input  logic signed [data_w-1:0] cur_du,
    output logic signed [data_w-1:0] pos_x,
    output logic signed [data_w-1:0] pos_y,
    output logic signed [data_w-1:0] pos_z,
    output logic signed [data_w-1:0] pos_u
);

    ////////////////////////////////////////////////////////////////////
    // position sums, wrap on overflow
    ////////////////////////////////////////////////////////////////////

    // x, y, z carry over from run to run
    always_ff @(posedge a_clk)
    begin
        if (reset_flg)
        begin
            pos_x <= '0;
            pos_y <= '0;
            pos_z <= '0;
        end
        else if (step)
        begin
            pos_x <= pos_x + cur_dx;
            pos_y <= pos_y + cur_dy;
            pos_z <= pos_z + cur_dz;
        end
    end

    // u restarts from zero each run
    always_ff @(posedge a_clk)
    begin
        if (reset_flg || clear_u)
            pos_u <= '0;
        else if (step)
            pos_u <= pos_u + cur_du;
    end

endmodule

// File: source/gvp_output_stage.sv
module gvp_output_stage
    import gvp_pkg::*;
(
    input  logic              a_clk,
    input  logic              reset_flg,
    input  store_code_t       store_code,     // from sequencer, tick only
    input  seq_state_t        state,
    input  logic [data_w-1:0] cur_options,    // options of vector at pc
    input  logic [data_w-1:0] reset_options,  // idle options
    output logic [data_w-1:0] options,
    output store_code_t       store_data,
    output logic [time_w-1:0] gvp_time,
    output logic              gvp_finished
);

    logic idle;  // held or finished

    assign idle = (state == seq_hold) || (state == seq_done);

    ////////////////////////////////////////////////////////////////////
    // store pulse and options
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (reset_flg)
        begin
            store_data <= store_none;
            options    <= '0;
        end
        else
        begin
            store_data <= store_code;  // one cycle behind the tick
            if (store_code == store_end)
                options <= end_options;    // end mark
            else if (idle)
                options <= reset_options;
            else
                options <= cur_options;
        end
    end

    // run time and finished flag
    always_ff @(posedge a_clk)
    begin
        if (reset_flg)
        begin
            gvp_time     <= '0;
            gvp_finished <= 1'b0;
        end
        else
        begin
            if (state == seq_hold)
                gvp_time <= '0;
            else
                gvp_time <= gvp_time + 1'b1;  // counts on through done
            gvp_finished <= (state == seq_done);  // low again once held
        end
    end

endmodule

// File: source/gvp_core.sv
module gvp_core
    import gvp_pkg::*;
(
    input  logic                     a_clk,
    input  logic                     reset_flg,
    input  logic                     run_hold,
    input  logic                     pause,
    input  logic                     stall,
    // vector programming
    input  logic                     setvec,
    input  logic [vec_addr_w-1:0]    vec_addr,
    input  logic [data_w-1:0]        vec_n,
    input  logic [data_w-1:0]        vec_iin,
    input  logic [data_w-1:0]        vec_options,
    input  logic [data_w-1:0]        vec_nrep,
    input  logic signed [next_w-1:0] vec_next,
    input  logic [data_w-1:0]        vec_deci,
    input  logic signed [data_w-1:0] vec_dx,
    input  logic signed [data_w-1:0] vec_dy,
    input  logic signed [data_w-1:0] vec_dz,
    input  logic signed [data_w-1:0] vec_du,
    input  logic [data_w-1:0]        reset_options,
    // results
    output logic signed [data_w-1:0] pos_x,
    output logic signed [data_w-1:0] pos_y,
    output logic signed [data_w-1:0] pos_z,
    output logic signed [data_w-1:0] pos_u,
    output logic [data_w-1:0]        options,
    output store_code_t              store_data,
    output logic [data_w-1:0]        index,
    output logic [time_w-1:0]        gvp_time,
    output logic                     gvp_finished,
    output logic                     gvp_hold
);

    // sequencer to store
    logic [vec_addr_w-1:0]    pc;
    logic                     loop_dec;
    logic                     loop_reload;
    // current vector fields
    logic [data_w-1:0]        cur_n;
    logic [data_w-1:0]        cur_iin;
    logic [data_w-1:0]        cur_options;
    logic signed [next_w-1:0] cur_next;
    logic [data_w-1:0]        cur_deci;
    logic signed [data_w-1:0] cur_dx;
    logic signed [data_w-1:0] cur_dy;
    logic signed [data_w-1:0] cur_dz;
    logic signed [data_w-1:0] cur_du;
    logic [data_w-1:0]        loop_count;
    // sequencer to execute and result
    logic                     step;
    logic                     clear_u;
    store_code_t              store_code;
    seq_state_t               state;

    gvp_vector_store i_vector_store (.a_clk, .reset_flg, .setvec, .vec_addr, .vec_n, .vec_iin,
        .vec_options, .vec_nrep, .vec_next, .vec_deci, .vec_dx, .vec_dy, .vec_dz, .vec_du,
        .pc, .loop_dec, .loop_reload, .cur_n, .cur_iin, .cur_options, .cur_next, .cur_deci,
        .cur_dx, .cur_dy, .cur_dz, .cur_du, .loop_count);

    gvp_sequencer i_sequencer (.a_clk, .reset_flg, .run_hold, .pause, .stall, .cur_n,
        .cur_iin, .cur_next, .cur_deci, .loop_count, .pc, .loop_dec, .loop_reload, .step,
        .clear_u, .store_code, .state, .index, .gvp_hold);

    gvp_accumulator i_accumulator (.a_clk, .reset_flg, .step, .clear_u, .cur_dx, .cur_dy,
        .cur_dz, .cur_du, .pos_x, .pos_y, .pos_z, .pos_u);

    gvp_output_stage i_output_stage (.a_clk, .reset_flg, .store_code, .state, .cur_options,
        .reset_options, .options, .store_data, .gvp_time, .gvp_finished);

endmodule

// File: verification/gvp_tb.sv
module gvp_tb
    import gvp_pkg::*;
();

    logic                     a_clk = 1'b0;
    logic                     reset_flg = 1'b1;
    logic                     run_hold = 1'b1;      // held while programming
    logic                     pause = 1'b0;
    logic                     stall = 1'b0;
    logic                     setvec = 1'b0;
    logic [vec_addr_w-1:0]    vec_addr = '0;
    logic [data_w-1:0]        vec_n = '0, vec_iin = '0, vec_options = '0, vec_nrep = '0;
    logic signed [next_w-1:0] vec_next = '0;
    logic [data_w-1:0]        vec_deci = '0, reset_options = '0;
    logic signed [data_w-1:0] vec_dx = '0, vec_dy = '0, vec_dz = '0, vec_du = '0;
    logic signed [data_w-1:0] pos_x, pos_y, pos_z, pos_u;
    logic [data_w-1:0]        options, index;
    store_code_t              store_data;
    logic [time_w-1:0]        gvp_time, last_pt_time;
    logic                     gvp_finished, gvp_hold;

    // program image kept by the testbench
    logic [data_w-1:0]        p_n [vec_count], p_iin [vec_count], p_opt [vec_count];
    logic [data_w-1:0]        p_nrep [vec_count], p_deci [vec_count];
    logic signed [next_w-1:0] p_next [vec_count];
    logic signed [data_w-1:0] p_dx [vec_count], p_dy [vec_count], p_dz [vec_count];
    logic signed [data_w-1:0] p_du [vec_count];
    int                       lc [vec_count];         // model loop counters
    logic signed [data_w-1:0] mx = 0, my = 0, mz = 0, mu = 0;  // model positions

    // expected store events, front is next
    logic [1:0]               exp_code [$];
    logic [data_w-1:0]        exp_index [$], exp_opt [$];
    logic signed [data_w-1:0] exp_x [$], exp_y [$], exp_z [$], exp_u [$];
    int                       exp_gap [$];            // 0 means no spacing check

    int   total_ticks, max_deci, errors, seed, pick;
    int   pause_used = 0;
    int   pause_cap = 0;
    bit   pause_en = 1'b0;
    bit   gap_check = 1'b0;
    logic hold_exp = 1'b0;

    always #4 a_clk = ~a_clk;

    gvp_core i_gvp_core (.*);

    ////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            errors++;
            fail_now($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // held state, also right after reset
    task automatic check_idle();
        check_value("store_data", store_data, store_none);
        check_value("gvp_finished", gvp_finished, 1'b0);
        check_value("gvp_time", gvp_time, 0);
        check_value("options", options, reset_options);
        check_value("pos_u", pos_u, 0);
    endtask

    ////////////////////////////////////////////////////////////////////
    // reference model, one pass over the program at tick level
    ////////////////////////////////////////////////////////////////////

    task automatic push_event(input logic [1:0] code, input logic [31:0] idx,
                              input logic [31:0] opt, input int gap);
        exp_code.push_back(code);
        exp_index.push_back(idx);
        exp_opt.push_back(opt);
        exp_gap.push_back(gap);
        exp_x.push_back(mx);
        exp_y.push_back(my);
        exp_z.push_back(mz);
        exp_u.push_back(mu);
    endtask

    task automatic run_model();
        int pc;
        int pt;
        int st;
        bit first;
        bit fin;
        bit sec_end;
        pc = 0;
        fin = 0;
        mu = 0;            // u restarts, x y z carry over
        total_ticks = 1;   // hold to load
        max_deci = 0;
        while (!fin)
        begin
            total_ticks++;  // load tick
            if (p_n[pc] == 0)
            begin
                push_event(store_end, 0, end_options, 0);
                fin = 1;
            end
            else
            begin
                push_event(store_header, p_n[pc], p_opt[pc], 0);
                if (p_deci[pc] > max_deci)
                    max_deci = p_deci[pc];
                pt = p_n[pc];
                st = p_iin[pc];
                first = 1;
                sec_end = 0;
                while (!sec_end)
                begin
                    total_ticks++;
                    mx = mx + p_dx[pc];  // every step adds, section end too
                    my = my + p_dy[pc];
                    mz = mz + p_dz[pc];
                    mu = mu + p_du[pc];
                    if (st != 0)
                        st--;
                    else if (pt != 0)
                    begin
                        pt--;
                        push_event(store_point, pt, p_opt[pc],
                                   first ? 0 : (p_iin[pc] + 1) * (p_deci[pc] + 1));
                        first = 0;
                        st = p_iin[pc];
                    end
                    else
                    begin
                        sec_end = 1;
                        if (lc[pc] != 0)
                        begin
                            lc[pc]--;             // loop taken
                            pc = pc + p_next[pc];
                        end
                        else
                        begin
                            lc[pc] = p_nrep[pc];  // rearmed for later passes
                            pc++;
                        end
                    end
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////

    // random program, last vector has n of 0, jumps only backward
    task automatic load_program();
        int nvec;
        nvec = $urandom_range(3, 8);
        for (int k = 0; k < nvec; k++)
        begin
            p_n[k]    = (k == nvec - 1) ? 0 : $urandom_range(1, 3);
            p_iin[k]  = $urandom_range(0, 2);
            p_opt[k]  = $urandom;
            p_nrep[k] = ($urandom_range(0, 2) == 0) ? $urandom_range(1, 2) : 0;
            p_next[k] = -$urandom_range(0, k);
            p_deci[k] = $urandom_range(0, 3);
            p_dx[k]   = $urandom_range(0, 40) - 20;
            p_dy[k]   = $urandom_range(0, 40) - 20;
            p_dz[k]   = $urandom_range(0, 40) - 20;
            p_du[k]   = $urandom_range(0, 40) - 20;
            lc[k]     = p_nrep[k];
            @(posedge a_clk);
            setvec      <= 1'b1;
            vec_addr    <= k;
            vec_n       <= p_n[k];
            vec_iin     <= p_iin[k];
            vec_options <= p_opt[k];
            vec_nrep    <= p_nrep[k];
            vec_next    <= p_next[k];
            vec_deci    <= p_deci[k];
            vec_dx      <= p_dx[k];
            vec_dy      <= p_dy[k];
            vec_dz      <= p_dz[k];
            vec_du      <= p_du[k];
        end
        @(posedge a_clk);
        setvec <= 1'b0;
        repeat (3)
        begin
            @(negedge a_clk);
            check_idle();
        end
    endtask

    task automatic run_program(input bit with_pause);
        int limit;
        int cycles;
        run_model();
        // a paused tick costs at most one extra decimation period
        limit = (total_ticks + (with_pause ? 150 : 0) + 4) * (max_deci + 1) + 50;
        gap_check = !with_pause;
        pause_cap = pause_used + 150;
        cycles = 0;
        @(posedge a_clk);
        run_hold <= 1'b0;
        pause_en <= with_pause;
        while (exp_code.size() != 0)
        begin
            @(negedge a_clk);
            cycles++;
            if (cycles > limit)
                fail_now("Timeout: the program did not reach its end mark in time");
        end
        @(posedge a_clk);
        pause_en <= 1'b0;
        repeat (4)
        begin
            @(negedge a_clk);  // finished, idle options, positions frozen
            check_value("gvp_finished", gvp_finished, 1'b1);
            check_value("options", options, reset_options);
            check_value("pos_x", pos_x, mx);
            check_value("pos_y", pos_y, my);
            check_value("pos_z", pos_z, mz);
            check_value("pos_u", pos_u, mu);
        end
        @(posedge a_clk);
        run_hold <= 1'b1;
        repeat (5) @(negedge a_clk);
        check_idle();
        check_value("pos_x", pos_x, mx);
    endtask

    // random pause and stall, capped per run
    always @(posedge a_clk)
    begin
        if (pause_en && pause_used < pause_cap)
        begin
            pick = $urandom_range(0, 7);
            pause <= (pick == 0);
            stall <= (pick == 1);
            if (pick < 2)
                pause_used++;
        end
        else
        begin
            pause <= 1'b0;
            stall <= 1'b0;
        end
        hold_exp <= !reset_flg && (pause || stall);  // registered OR
    end

    // event monitor, outputs are stable at the falling edge
    always @(negedge a_clk)
    begin
        check_value("gvp_hold", gvp_hold, hold_exp);
        if (store_data != store_none)
        begin
            if (exp_code.size() == 0)
                fail_now("Store event seen after the model's event list ran out");
            else
            begin
                check_value("store_data", store_data, exp_code.pop_front());
                check_value("index", index, exp_index.pop_front());
                check_value("options", options, exp_opt.pop_front());
                check_value("pos_x", pos_x, exp_x.pop_front());
                check_value("pos_y", pos_y, exp_y.pop_front());
                check_value("pos_z", pos_z, exp_z.pop_front());
                check_value("pos_u", pos_u, exp_u.pop_front());
                pick = exp_gap.pop_front();
                if (store_data == store_point)
                begin
                    if (gap_check && pick != 0)
                        check_value("gvp_time", gvp_time - last_pt_time, pick);
                    last_pt_time = gvp_time;
                end
            end
        end
    end

    initial
    begin
        errors = 0;
        seed = $urandom(41);
        reset_options = $urandom;
        repeat (3) @(posedge a_clk);
        reset_flg <= 1'b0;
        @(negedge a_clk);  // options still at the reset value here
        check_value("store_data", store_data, store_none);
        check_value("gvp_finished", gvp_finished, 1'b0);
        check_value("gvp_time", gvp_time, 0);
        repeat (3)
        begin
            @(negedge a_clk);
            check_idle();
        end
        for (int p = 0; p < 4; p++)
        begin
            load_program();
            run_program(1'b0);  // clean run, spacing checked
            run_program(1'b1);  // same program under back-pressure
        end
        if (errors == 0)
        begin
            $display("Finished with no errors");
            $finish;
        end
        else
        begin
            $display("Finished with errors");
            $fatal(1);
        end
    end

endmodule

// File: project.f
source/gvp_pkg.sv
source/gvp_vector_store.sv
source/gvp_sequencer.sv
source/gvp_accumulator.sv
source/gvp_output_stage.sv
source/gvp_core.sv
verification/gvp_tb.sv
